/* call_pkg.sv */
// call unit shared definitions
// widths, execution steps, condition fields and CALL opcodes
`default_nettype none

package call_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [3:0]  flags_t;
    typedef logic [2:0]  cond_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read_low,
        st_read_high_push_high,
        st_push_low,
        st_load_pc,
        st_done
    } step_t;

    // bit positions in flags_t
    localparam int flag_z  = 0;
    localparam int flag_c  = 1;
    localparam int flag_pv = 2;
    localparam int flag_s  = 3;

    // ccc[2:1] flag selector
    localparam logic [1:0] sel_z  = 2'b00;
    localparam logic [1:0] sel_c  = 2'b01;
    localparam logic [1:0] sel_pv = 2'b10;
    localparam logic [1:0] sel_s  = 2'b11;

    localparam opcode_t op_call_nn    = 8'hCD;
    localparam opcode_t call_cc_mask  = 8'hC7;
    localparam opcode_t call_cc_match = 8'hC4;

endpackage

`default_nettype wire

/* mem_bus_if.sv */
// memory request channel between one bus user and the arbiter
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;
    import call_pkg::*;

    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  done;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

/* call_decoder.sv */
// CALL decoder
// opcode, step and flags to per-step request strobes
`timescale 1ns/100ps
`default_nettype none

module call_decoder (
    input  wire call_pkg::opcode_t opcode,
    input  wire call_pkg::step_t   step,
    input  wire call_pkg::flags_t  flags,
    output logic                   is_call,
    output logic                   taken,
    output logic                   want_read_low,
    output logic                   want_read_high,
    output logic                   want_push_high,
    output logic                   want_push_low,
    output logic                   want_load_pc
);
    import call_pkg::*;

    cond_t cond;
    logic  is_call_nn;
    logic  is_call_cc;
    logic  flag_sel;
    logic  flag_clear;
    logic  cond_true;

    assign cond       = opcode[5:3];
    assign is_call_nn = (opcode == op_call_nn);
    assign is_call_cc = ((opcode & call_cc_mask) == call_cc_match);
    assign is_call    = is_call_nn | is_call_cc;

    always_comb begin
        case (cond[2:1])
            sel_z:   flag_sel = flags[flag_z];
            sel_c:   flag_sel = flags[flag_c];
            sel_pv:  flag_sel = flags[flag_pv];
            sel_s:   flag_sel = flags[flag_s];
            default: flag_sel = 1'b0;
        endcase
    end

    // ccc[0] picks the polarity
    assign flag_clear = ~flag_sel;
    assign cond_true  = cond[0] ? flag_sel : flag_clear;
    assign taken      = is_call_nn | (is_call_cc & cond_true);

    // operand reads for any CALL, pushes only when taken
    assign want_read_low  = is_call & (step == st_read_low);
    assign want_read_high = is_call & (step == st_read_high_push_high);
    assign want_push_high = taken & (step == st_read_high_push_high);
    assign want_push_low  = taken & (step == st_push_low);
    assign want_load_pc   = (step == st_load_pc);

endmodule

`default_nettype wire

/* call_sequencer.sv */
// CALL sequencer
// steps through one instruction and owns pc and sp
`timescale 1ns/100ps
`default_nettype none

module call_sequencer #(
    parameter call_pkg::addr_t RESET_PC = 16'h0000,
    parameter call_pkg::addr_t RESET_SP = 16'hFFFE
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire call_pkg::opcode_t opcode,
    input  wire call_pkg::flags_t  flags,
    input  wire call_pkg::addr_t   target,
    input  wire                    read_finished,
    input  wire                    push_finished,
    output logic                   read_go,
    output logic                   read_high_sel,
    output logic                   push_go,
    output logic                   push_high_sel,
    output call_pkg::addr_t        push_addr,
    output call_pkg::addr_t        return_addr,
    output call_pkg::addr_t        pc,
    output call_pkg::addr_t        sp,
    output logic                   busy,
    output logic                   done
);
    import call_pkg::*;

    step_t   step;
    opcode_t op_q;
    flags_t  flags_q;
    opcode_t dec_op;
    flags_t  dec_flags;
    logic    issued;
    logic    read_seen;
    logic    push_seen;
    logic    read_ok;
    logic    push_ok;
    logic    accept;
    logic    is_call;
    logic    taken;
    logic    want_read_low;
    logic    want_read_high;
    logic    want_push_high;
    logic    want_push_low;
    logic    want_load_pc;

    // live opcode while waiting, so a no-op skips the read steps
    assign dec_op    = busy ? op_q : opcode;
    assign dec_flags = busy ? flags_q : flags;

    call_decoder decoder_inst (
        .opcode         (dec_op),
        .step           (step),
        .flags          (dec_flags),
        .is_call        (is_call),
        .taken          (taken),
        .want_read_low  (want_read_low),
        .want_read_high (want_read_high),
        .want_push_high (want_push_high),
        .want_push_low  (want_push_low),
        .want_load_pc   (want_load_pc)
    );

    assign accept        = start & ~busy;
    assign read_go       = (want_read_low | want_read_high) & ~issued;
    assign read_high_sel = want_read_high;
    assign push_go       = (want_push_high | want_push_low) & ~issued;
    assign push_high_sel = want_push_high;
    assign push_addr     = want_push_high ? sp - addr_t'(1) : sp - addr_t'(2);
    assign return_addr   = pc + addr_t'(3);

    // combined step finishes once both sides are in
    assign read_ok = read_seen | read_finished;
    assign push_ok = ~want_push_high | push_seen | push_finished;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= opcode;
            flags_q <= flags;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step      <= st_idle;
            busy      <= 1'b0;
            done      <= 1'b0;
            issued    <= 1'b0;
            read_seen <= 1'b0;
            push_seen <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                issued    <= 1'b0;
                read_seen <= 1'b0;
                push_seen <= 1'b0;
                step      <= is_call ? st_read_low : st_load_pc;
            end else begin
                case (step)
                    st_read_low: begin
                        issued <= 1'b1;
                        if (read_finished) begin
                            issued <= 1'b0;
                            step   <= st_read_high_push_high;
                        end
                    end
                    st_read_high_push_high: begin
                        issued <= 1'b1;
                        if (read_finished) read_seen <= 1'b1;
                        if (push_finished) push_seen <= 1'b1;
                        if (read_ok && push_ok) begin
                            issued    <= 1'b0;
                            read_seen <= 1'b0;
                            push_seen <= 1'b0;
                            step      <= taken ? st_push_low : st_load_pc;
                        end
                    end
                    st_push_low: begin
                        issued <= 1'b1;
                        if (push_finished) begin
                            issued <= 1'b0;
                            step   <= st_load_pc;
                        end
                    end
                    st_load_pc: begin
                        step <= st_done;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                    default: step <= st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
            sp <= RESET_SP;
        end else if (want_load_pc) begin
            if (taken) begin
                pc <= target;
                sp <= sp - addr_t'(2);
            end else if (is_call) begin
                pc <= pc + addr_t'(3);
            end else begin
                pc <= pc + addr_t'(1);
            end
        end
    end

    done_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> step != st_idle);

endmodule

`default_nettype wire

/* operand_reader.sv */
// operand reader
// fetches the nn bytes after the opcode and assembles the target
`timescale 1ns/100ps
`default_nettype none

module operand_reader (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  read_go,
    input  wire                  read_high_sel,
    input  wire call_pkg::addr_t base_pc,
    mem_bus_if.requester         bus,
    output logic                 read_finished,
    output call_pkg::addr_t      target
);
    import call_pkg::*;

    logic  req_q;
    logic  high_q;
    addr_t addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q         <= 1'b0;
            read_finished <= 1'b0;
        end else begin
            read_finished <= 1'b0;
            if (read_go) begin
                req_q <= 1'b1;
            end else if (bus.done) begin
                req_q         <= 1'b0;
                read_finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_go) begin
            addr_q <= base_pc + (read_high_sel ? addr_t'(2) : addr_t'(1));
            high_q <= read_high_sel;
        end
        if (bus.done) begin
            if (high_q) target[15:8] <= bus.rdata;
            else target[7:0] <= bus.rdata;
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = 1'b0;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

endmodule

`default_nettype wire

/* stack_writer.sv */
// stack writer
// pushes one return address byte per request
`timescale 1ns/100ps
`default_nettype none

module stack_writer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  push_go,
    input  wire                  push_high_sel,
    input  wire call_pkg::addr_t push_addr,
    input  wire call_pkg::addr_t return_addr,
    mem_bus_if.requester         bus,
    output logic                 push_finished
);
    import call_pkg::*;

    logic  req_q;
    addr_t addr_q;
    data_t wdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q         <= 1'b0;
            push_finished <= 1'b0;
        end else begin
            push_finished <= 1'b0;
            if (push_go) begin
                req_q <= 1'b1;
            end else if (bus.done) begin
                req_q         <= 1'b0;
                push_finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_go) begin
            addr_q  <= push_addr;
            wdata_q <= push_high_sel ? return_addr[15:8] : return_addr[7:0];
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = 1'b1;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

endmodule

`default_nettype wire

/* bus_arbiter.sv */
// bus arbiter
// reader before writer, one APB transfer per grant
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  wire                  clk,
    input  wire                  rst_n,
    mem_bus_if.arbiter           rd_bus,
    mem_bus_if.arbiter           wr_bus,
    output call_pkg::addr_t      paddr,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output call_pkg::data_t      pwdata,
    input  wire call_pkg::data_t prdata,
    input  wire                  pready
);
    import call_pkg::*;

    typedef enum logic [1:0] {
        arb_idle,
        arb_setup,
        arb_access
    } arb_state_t;

    arb_state_t state;
    logic [1:0] grant;
    logic       rd_done_q;
    logic       wr_done_q;
    logic       rd_ok;
    logic       wr_ok;
    data_t      rdata_q;

    // a requester still holds req in its done cycle
    assign rd_ok = rd_bus.req & ~rd_done_q;
    assign wr_ok = wr_bus.req & ~wr_done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= arb_idle;
            grant     <= 2'b00;
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
            case (state)
                arb_idle: begin
                    if (rd_ok) begin
                        grant <= 2'b01;
                        state <= arb_setup;
                    end else if (wr_ok) begin
                        grant <= 2'b10;
                        state <= arb_setup;
                    end
                end
                arb_setup: state <= arb_access;
                arb_access: begin
                    if (pready) begin
                        rd_done_q <= grant[0];
                        wr_done_q <= grant[1];
                        grant     <= 2'b00;
                        state     <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // transfer fields captured at grant, held to the end of access
    always_ff @(posedge clk) begin
        if (state == arb_idle) begin
            if (rd_ok) begin
                paddr  <= rd_bus.addr;
                pwrite <= rd_bus.we;
                pwdata <= rd_bus.wdata;
            end else if (wr_ok) begin
                paddr  <= wr_bus.addr;
                pwrite <= wr_bus.we;
                pwdata <= wr_bus.wdata;
            end
        end
        if (state == arb_access && pready) rdata_q <= prdata;
    end

    assign psel    = (state != arb_idle);
    assign penable = (state == arb_access);

    assign rd_bus.done  = rd_done_q;
    assign rd_bus.rdata = rdata_q;
    assign wr_bus.done  = wr_done_q;
    assign wr_bus.rdata = rdata_q;

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

    paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !pready |=> $stable(paddr));

endmodule

`default_nettype wire

/* call_unit_top.sv */
// CALL execution unit
// sequencer, two bus users and the APB arbiter
`timescale 1ns/100ps
`default_nettype none

module call_unit_top #(
    parameter call_pkg::addr_t RESET_PC = 16'h0000,
    parameter call_pkg::addr_t RESET_SP = 16'hFFFE
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire  [7:0]  opcode,
    input  wire  [3:0]  flags,
    output wire  [15:0] pc,
    output wire  [15:0] sp,
    output wire         busy,
    output wire         done,
    output wire  [15:0] paddr,
    output wire         psel,
    output wire         penable,
    output wire         pwrite,
    output wire  [7:0]  pwdata,
    input  wire  [7:0]  prdata,
    input  wire         pready
);
    import call_pkg::*;

    addr_t target;
    addr_t push_addr;
    addr_t return_addr;
    logic  read_go;
    logic  read_high_sel;
    logic  read_finished;
    logic  push_go;
    logic  push_high_sel;
    logic  push_finished;

    mem_bus_if rd_bus ();
    mem_bus_if wr_bus ();

    call_sequencer #(
        .RESET_PC (RESET_PC),
        .RESET_SP (RESET_SP)
    ) sequencer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .opcode        (opcode),
        .flags         (flags),
        .target        (target),
        .read_finished (read_finished),
        .push_finished (push_finished),
        .read_go       (read_go),
        .read_high_sel (read_high_sel),
        .push_go       (push_go),
        .push_high_sel (push_high_sel),
        .push_addr     (push_addr),
        .return_addr   (return_addr),
        .pc            (pc),
        .sp            (sp),
        .busy          (busy),
        .done          (done)
    );

    operand_reader reader_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .read_go       (read_go),
        .read_high_sel (read_high_sel),
        .base_pc       (pc),
        .bus           (rd_bus.requester),
        .read_finished (read_finished),
        .target        (target)
    );

    stack_writer writer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .push_go       (push_go),
        .push_high_sel (push_high_sel),
        .push_addr     (push_addr),
        .return_addr   (return_addr),
        .bus           (wr_bus.requester),
        .push_finished (push_finished)
    );

    bus_arbiter arbiter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_bus  (rd_bus.arbiter),
        .wr_bus  (wr_bus.arbiter),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

`default_nettype wire

/* apb_mem_model.sv */
// APB memory model for the testbench
// byte memory with programmable wait states and a transfer log
`timescale 1ns/100ps
`default_nettype none

module apb_mem_model #(
    parameter int LOG_DEPTH = 256
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [1:0]  wait_states,
    input  wire  [15:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready
);

    logic [7:0]  mem [0:65535];
    logic [15:0] log_addr [0:LOG_DEPTH-1];
    logic        log_write [0:LOG_DEPTH-1];
    logic [7:0]  log_data [0:LOG_DEPTH-1];
    int          log_count;
    logic [1:0]  wait_cnt;

    assign prdata = mem[paddr];
    // ready after wait_states extra access cycles
    assign pready = psel && penable && (wait_cnt == wait_states);

    always @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt  <= 2'd0;
            log_count <= 0;
        end else if (psel && penable) begin
            if (pready) begin
                wait_cnt <= 2'd0;
                if (pwrite) mem[paddr] <= pwdata;
                log_addr[log_count % LOG_DEPTH]  <= paddr;
                log_write[log_count % LOG_DEPTH] <= pwrite;
                log_data[log_count % LOG_DEPTH]  <= pwrite ? pwdata : mem[paddr];
                log_count <= log_count + 1;
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_call_unit.sv */
// testbench for the CALL execution unit
// random memory and flags, reference pc/sp model, APB protocol checks
`timescale 1ns/100ps
`default_nettype none

module tb_call_unit;
    import call_pkg::*;

    localparam logic [15:0] RESET_PC = 16'h0100;
    localparam logic [15:0] RESET_SP = 16'hF000;
    localparam int N_CALL_NN  = 4;
    localparam int N_RANDOM   = 10;
    localparam int N_INSTR    = N_CALL_NN + 16 + 2 + N_RANDOM;
    localparam int MAX_CYCLES = 40 * N_INSTR;
    localparam int LOG_DEPTH  = 256;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [7:0]  opcode;
    logic [3:0]  flags;
    logic [15:0] pc;
    logic [15:0] sp;
    logic        busy;
    logic        done;
    logic [15:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic [1:0]  wait_states;
    logic        noop_active;
    logic [31:0] lcg_state;
    logic [15:0] ref_pc;
    logic [15:0] ref_sp;
    int          cycle_count = 0;

    call_unit_top #(
        .RESET_PC (RESET_PC),
        .RESET_SP (RESET_SP)
    ) call_unit_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .opcode  (opcode),
        .flags   (flags),
        .pc      (pc),
        .sp      (sp),
        .busy    (busy),
        .done    (done),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    apb_mem_model #(
        .LOG_DEPTH (LOG_DEPTH)
    ) mem_model_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wait_states (wait_states),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
                                $time, what, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_transfer(input int pos, input logic [15:0] addr,
                                  input logic write, input logic [7:0] data);
        int idx;
        idx = pos % LOG_DEPTH;
        check_equal("transfer address", mem_model_inst.log_addr[idx], addr);
        check_equal("transfer direction", mem_model_inst.log_write[idx], write);
        if (write) check_equal("pushed byte", mem_model_inst.log_data[idx], data);
    endtask

    // one instruction against the reference pc/sp model
    task automatic run_instr(input logic [7:0] op, input logic [3:0] f, input bit spurious);
        logic        call;
        logic        tk;
        logic [2:0]  ccc;
        logic [15:0] a1;
        logic [15:0] a2;
        logic [15:0] ret;
        logic [15:0] nn;
        logic [15:0] push_hi;
        logic [15:0] push_lo;
        logic [15:0] rnd;
        int          base;
        int          n;
        int          exp_count;
        ccc     = op[5:3];
        call    = (op == op_call_nn) || ((op & call_cc_mask) == call_cc_match);
        tk      = (op == op_call_nn) || (call && (f[ccc[2:1]] == ccc[0]));
        a1      = ref_pc + 16'd1;
        a2      = ref_pc + 16'd2;
        ret     = ref_pc + 16'd3;
        push_hi = ref_sp - 16'd1;
        push_lo = ref_sp - 16'd2;
        nn      = {mem_model_inst.mem[a2], mem_model_inst.mem[a1]};
        base    = mem_model_inst.log_count;
        exp_count = tk ? 4 : (call ? 2 : 0);
        rnd         = lcg_next();
        wait_states = rnd[1:0];
        opcode      = op;
        flags       = f;
        start       = 1'b1;
        noop_active = !call;
        n = 0;
        do begin
            next_cycle();
            n++;
            start = 1'b0;
            // a second start while busy must be dropped
            if (spurious && n == 3 && busy) begin
                rnd    = lcg_next();
                start  = 1'b1;
                opcode = rnd[7:0];
                flags  = rnd[11:8];
            end
        end while (!done);
        start       = 1'b0;
        if (!call) check_equal("no-op latency", n, 2);
        if (tk) begin
            ref_pc = nn;
            ref_sp = ref_sp - 16'd2;
        end else if (call) begin
            ref_pc = ret;
        end else begin
            ref_pc = ref_pc + 16'd1;
        end
        check_equal("pc", pc, ref_pc);
        check_equal("sp", sp, ref_sp);
        check_equal("busy at done", busy, 0);
        check_equal("transfer count", mem_model_inst.log_count - base, exp_count);
        if (call) begin
            check_transfer(base, a1, 1'b0, 8'h00);
            check_transfer(base + 1, a2, 1'b0, 8'h00);
        end
        if (tk) begin
            check_transfer(base + 2, push_hi, 1'b1, ret[15:8]);
            check_transfer(base + 3, push_lo, 1'b1, ret[7:0]);
        end
        next_cycle();
        check_equal("done after its pulse", done, 0);
        // a stray transfer from a no-op would reach psel within these cycles
        if (!call) repeat (3) next_cycle();
        noop_active = 1'b0;
    endtask

    initial begin
        logic [15:0] rnd;
        logic [7:0]  op;
        logic [3:0]  f;
        int          addr;
        lcg_state   = 32'h9e22;
        rst_n       = 1'b0;
        start       = 1'b0;
        opcode      = 8'h00;
        flags       = 4'h0;
        wait_states = 2'd0;
        noop_active = 1'b0;
        // random bytes with the high address byte folded in
        for (addr = 0; addr < 65536; addr++) begin
            rnd = lcg_next();
            mem_model_inst.mem[addr] = rnd[7:0] ^ addr[15:8];
        end
        repeat (8) next_cycle();
        check_equal("pc after reset", pc, RESET_PC);
        check_equal("sp after reset", sp, RESET_SP);
        check_equal("psel after reset", psel, 0);
        check_equal("penable after reset", penable, 0);
        check_equal("busy after reset", busy, 0);
        check_equal("done after reset", done, 0);
        rst_n = 1'b1;
        next_cycle();
        ref_pc = RESET_PC;
        ref_sp = RESET_SP;

        for (int i = 0; i < N_CALL_NN; i++) begin
            rnd = lcg_next();
            run_instr(op_call_nn, rnd[3:0], i[0]);
        end

        // each ccc with its flag both ways
        for (int i = 0; i < 8; i++) begin
            rnd = lcg_next();
            op  = call_cc_match | {2'b00, i[2:0], 3'b000};
            f   = rnd[3:0];
            run_instr(op, f, 1'b0);
            run_instr(op, f ^ (4'b0001 << i[2:1]), i[0]);
        end

        run_instr(8'h00, 4'hF, 1'b0);
        run_instr(8'hC9, 4'h0, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = lcg_next();
            run_instr(rnd[7:0], rnd[11:8], i[0]);
        end

        $display("All tests passed!");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel && !penable))
        else abort_run("APB protocol error: access phase without a setup cycle");

    penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else abort_run("APB protocol error: penable high while psel is low");

    apb_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !(penable && pready) |=>
            $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else abort_run("APB protocol error: address or data changed before pready");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        penable && pready |=> !penable)
        else abort_run("APB protocol error: transfer ran into the next one");

    noop_quiet_bus: assert property (@(posedge clk) disable iff (!rst_n)
        noop_active |-> !psel)
        else abort_run("Bus error: a non-CALL opcode started an APB transfer");

endmodule

`default_nettype wire

/* project.f */
call_pkg.sv
mem_bus_if.sv
call_decoder.sv
call_sequencer.sv
operand_reader.sv
stack_writer.sv
bus_arbiter.sv
call_unit_top.sv
apb_mem_model.sv
tb_call_unit.sv

/* Bender.yml */
package:
  name: call_unit

sources:
  - call_pkg.sv
  - mem_bus_if.sv
  - call_decoder.sv
  - call_sequencer.sv
  - operand_reader.sv
  - stack_writer.sv
  - bus_arbiter.sv
  - call_unit_top.sv
  - target: test
    files:
      - apb_mem_model.sv
      - tb_call_unit.sv
